/* dv/trap_unit_tb.sv */
/* directed testbench for the trap-entry unit, drives trap sources, the ack
   handshake and apb accesses, and checks responses against the trap rules */

`timescale 1ns/1ps

module trap_unit_tb;

  localparam int NUM_IRQ     = 32;
  localparam int CYCLE_LIMIT = 3000;

  logic               clk;
  logic               rst_n;
  logic [NUM_IRQ-1:0] irq_i;
  logic               illegal_insn_i;
  logic               ecall_insn_i;
  logic               eret_insn_i;
  logic               req_o;
  logic               ack_i;
  logic [5:0]         cause_o;
  logic [31:0]        handler_pc_o;
  logic               psel_i;
  logic               penable_i;
  logic               pwrite_i;
  logic [3:0]         paddr_i;
  logic [31:0]        pwdata_i;
  logic [31:0]        prdata_o;
  logic               pready_o;
  logic               pslverr_o;

  int                 cycles = 0;
  integer             seed;
  string              test_name;
  // TVEC as it should read back, low byte cleared
  logic [31:0]        tvec_exp;
  // cause of the last acknowledged transfer
  logic [31:0]        last_cause;

  trap_unit #(
    .NUM_IRQ        (NUM_IRQ)
  ) dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_i          (irq_i),
    .illegal_insn_i (illegal_insn_i),
    .ecall_insn_i   (ecall_insn_i),
    .eret_insn_i    (eret_insn_i),
    .req_o          (req_o),
    .ack_i          (ack_i),
    .cause_o        (cause_o),
    .handler_pc_o   (handler_pc_o),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit in clock cycles
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout: simulation ran past %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Mismatch %s %s expected %h actual %h", test_name, what, exp, act);
      $display("Done: errors found");
      $fatal(1, "value check failed");
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    tick();
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    tick();
    penable_i = 1'b1;
    tick();
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  // data and error sampled mid access cycle
  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    tick();
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    tick();
    penable_i = 1'b1;
    @(negedge clk);
    data = prdata_o;
    err  = pslverr_o;
    tick();
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic read_check(input string what, input logic [3:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_read(addr, rd, err);
    check(what, exp, rd);
    check({what, " pslverr"}, 32'h0, 32'(err));
  endtask

  // lowest line that is both raised and unmasked, -1 if none
  function automatic int lowest_pending(input logic [31:0] lines, input logic [31:0] mask);
    logic [31:0] pend;
    int          n;
    pend = lines & mask;
    n    = -1;
    for (int i = 0; i < NUM_IRQ; i++)
    begin
      if (pend[i] && n < 0)
        n = i;
    end
    return n;
  endfunction

  // ack one cycle into a pending request, optionally drop all sources after
  task automatic ack_request(input logic [31:0] exp_cause, input logic clear_src);
    tick();
    ack_i = 1'b1;
    @(negedge clk);
    check("req in ack cycle", 32'h1, 32'(req_o));
    check("cause in ack cycle", exp_cause, 32'(cause_o));
    tick();
    ack_i      = 1'b0;
    last_cause = exp_cause;
    if (clear_src)
    begin
      illegal_insn_i = 1'b0;
      ecall_insn_i   = 1'b0;
      irq_i          = '0;
    end
  endtask

  task automatic return_from_handler();
    tick();
    eret_insn_i = 1'b1;
    tick();
    eret_insn_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset_regs();
    logic [31:0] rd;
    logic        err;
    test_name = "reset_regs";
    check("req after reset", 32'h0, 32'(req_o));
    check("pready", 32'h1, 32'(pready_o));
    read_check("status reset", trap_pkg::REG_STATUS, 32'h0);
    read_check("mask reset", trap_pkg::REG_IRQ_MASK, 32'h0);
    read_check("cause reset", trap_pkg::REG_CAUSE, 32'h0);
    read_check("tvec reset", trap_pkg::REG_TVEC, 32'h0);
    // only bit 0 is writable, bit 1 is the handler flag
    apb_write(trap_pkg::REG_STATUS, 32'hFFFF_FFFF);
    read_check("status rw", trap_pkg::REG_STATUS, 32'h1);
    apb_write(trap_pkg::REG_IRQ_MASK, 32'hA5A5_1234);
    read_check("mask rw", trap_pkg::REG_IRQ_MASK, 32'hA5A5_1234);
    apb_write(trap_pkg::REG_TVEC, 32'h1234_5678);
    read_check("tvec rw", trap_pkg::REG_TVEC, 32'h1234_5600);
    apb_write(trap_pkg::REG_CAUSE, 32'h0000_003F);
    read_check("cause read-only", trap_pkg::REG_CAUSE, 32'h0);
    // paddr is 4 bits wide, so unmapped means off the word grid
    apb_read(4'h2, rd, err);
    check("pslverr offset 2", 32'h1, 32'(err));
    apb_read(4'h6, rd, err);
    check("pslverr offset 6", 32'h1, 32'(err));
  endtask

  task automatic test_exceptions();
    test_name = "exceptions";
    apb_write(trap_pkg::REG_TVEC, 32'h8000_4A5C);
    tvec_exp = 32'h8000_4A00;
    apb_write(trap_pkg::REG_IRQ_MASK, 32'hFFFF_FFFF);
    apb_write(trap_pkg::REG_STATUS, 32'h1);
    // line 0 gets registered first so it competes in the same cycle
    tick();
    irq_i          = 32'h0000_0001;
    tick();
    // all three sources at once, illegal wins
    illegal_insn_i = 1'b1;
    ecall_insn_i   = 1'b1;
    @(negedge clk);
    check("req illegal", 32'h1, 32'(req_o));
    check("cause illegal", 32'h2, 32'(cause_o));
    check("pc illegal", tvec_exp + 32'h8, handler_pc_o);
    ack_request(32'h2, 1'b1);
    return_from_handler();
    read_check("saved illegal", trap_pkg::REG_CAUSE, 32'h2);
    tick();
    ecall_insn_i = 1'b1;
    @(negedge clk);
    check("req ecall", 32'h1, 32'(req_o));
    check("cause ecall", 32'h8, 32'(cause_o));
    check("pc ecall", tvec_exp + 32'h20, handler_pc_o);
    ack_request(32'h8, 1'b1);
    return_from_handler();
    read_check("saved ecall", trap_pkg::REG_CAUSE, 32'h8);
  endtask

  task automatic test_irq_select();
    logic [31:0] pattern;
    logic [31:0] mask;
    int          n;
    test_name = "irq_select";
    for (int k = 0; k < 24; k++)
    begin
      pattern = $random(seed);
      mask    = $random(seed);
      // every fourth round nothing is pending
      if (k % 4 == 3)
        mask = ~pattern;
      apb_write(trap_pkg::REG_IRQ_MASK, mask);
      n = lowest_pending(pattern, mask);
      tick();
      irq_i = pattern;
      @(negedge clk);
      check("req before line registered", 32'h0, 32'(req_o));
      tick();
      @(negedge clk);
      if (n >= 0)
      begin
        check("req pending", 32'h1, 32'(req_o));
        check("cause irq", 32'h20 + 32'(n), 32'(cause_o));
        check("pc irq", tvec_exp + 32'h80 + 32'(n * 4), handler_pc_o);
        ack_request(32'h20 + 32'(n), 1'b1);
        return_from_handler();
      end
      else
      begin
        check("req none pending", 32'h0, 32'(req_o));
        tick();
        irq_i = '0;
        tick();
      end
    end
    // global enable off blocks every source
    apb_write(trap_pkg::REG_STATUS, 32'h0);
    apb_write(trap_pkg::REG_IRQ_MASK, 32'hFFFF_FFFF);
    tick();
    irq_i          = '1;
    illegal_insn_i = 1'b1;
    ecall_insn_i   = 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      check("req while disabled", 32'h0, 32'(req_o));
      tick();
    end
    irq_i          = '0;
    illegal_insn_i = 1'b0;
    ecall_insn_i   = 1'b0;
    tick();
    tick();
    apb_write(trap_pkg::REG_STATUS, 32'h1);
  endtask

  task automatic test_backpressure();
    test_name = "backpressure";
    tick();
    irq_i = 32'h0000_0100;
    @(negedge clk);
    check("req before line registered", 32'h0, 32'(req_o));
    tick();
    @(negedge clk);
    check("req line 8", 32'h1, 32'(req_o));
    check("cause line 8", 32'h28, 32'(cause_o));
    // ack held low, lines churn underneath
    repeat (5)
    begin
      tick();
      irq_i = $random(seed) | 32'h1;
      @(negedge clk);
      check("req held", 32'h1, 32'(req_o));
      check("cause held", 32'h28, 32'(cause_o));
      check("pc held", tvec_exp + 32'h80 + 32'h20, handler_pc_o);
    end
    ack_request(32'h28, 1'b0);
    irq_i          = 32'h0000_0008;
    illegal_insn_i = 1'b1;
    repeat (4)
    begin
      @(negedge clk);
      check("req in handler", 32'h0, 32'(req_o));
      tick();
    end
    illegal_insn_i = 1'b0;
    eret_insn_i    = 1'b1;
    @(negedge clk);
    check("req during eret", 32'h0, 32'(req_o));
    tick();
    eret_insn_i = 1'b0;
    // line 3 never dropped, so it comes straight back
    @(negedge clk);
    check("req after eret", 32'h1, 32'(req_o));
    check("cause line 3", 32'h23, 32'(cause_o));
    check("pc line 3", tvec_exp + 32'h80 + 32'hC, handler_pc_o);
    ack_request(32'h23, 1'b1);
    return_from_handler();
  endtask

  task automatic test_isr_flag();
    test_name = "isr_flag";
    read_check("cause before", trap_pkg::REG_CAUSE, last_cause);
    tick();
    ecall_insn_i = 1'b1;
    @(negedge clk);
    check("req ecall", 32'h1, 32'(req_o));
    check("cause ecall", 32'h8, 32'(cause_o));
    repeat (3)
    begin
      tick();
      @(negedge clk);
      check("req waiting", 32'h1, 32'(req_o));
    end
    // not transferred yet, register keeps the old cause
    read_check("cause waiting", trap_pkg::REG_CAUSE, last_cause);
    read_check("status waiting", trap_pkg::REG_STATUS, 32'h1);
    ack_request(32'h8, 1'b0);
    read_check("status in handler", trap_pkg::REG_STATUS, 32'h3);
    read_check("cause saved", trap_pkg::REG_CAUSE, 32'h8);
    tick();
    illegal_insn_i = 1'b1;
    @(negedge clk);
    check("req ignored", 32'h0, 32'(req_o));
    read_check("cause unchanged", trap_pkg::REG_CAUSE, 32'h8);
    illegal_insn_i = 1'b0;
    ecall_insn_i   = 1'b0;
    return_from_handler();
    read_check("status after eret", trap_pkg::REG_STATUS, 32'h1);
    read_check("cause after eret", trap_pkg::REG_CAUSE, 32'h8);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    seed           = 74;
    rst_n          = 1'b0;
    irq_i          = '0;
    illegal_insn_i = 1'b0;
    ecall_insn_i   = 1'b0;
    eret_insn_i    = 1'b0;
    ack_i          = 1'b0;
    psel_i         = 1'b0;
    penable_i      = 1'b0;
    pwrite_i       = 1'b0;
    paddr_i        = '0;
    pwdata_i       = '0;
    tvec_exp       = '0;
    last_cause     = '0;
    test_name      = "init";
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_regs();
    test_exceptions();
    test_irq_select();
    test_backpressure();
    test_isr_flag();

    $display("Done: no errors");
    $finish;
  end

endmodule

/* project.f */
source/trap_pkg.sv
source/trap_csr_if.sv
source/trap_source_arbiter.sv
source/trap_ctrl.sv
source/trap_csr_apb.sv
source/trap_unit.sv
dv/trap_unit_tb.sv

/* run.sh */
#!/bin/sh
# build the trap unit testbench with Verilator and run it
# a failing check ends the simulation with a nonzero status
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
  -f project.f \
  --top-module trap_unit_tb \
  -o trap_unit_sim

./obj_dir/trap_unit_sim

/* source/trap_csr_apb.sv */
/* apb register block of the trap unit with STATUS, IRQ_MASK, CAUSE and TVEC
   also forms the handler address from TVEC and the live cause */

`timescale 1ns/1ps

module trap_csr_apb #(
  parameter int NUM_IRQ = 32
) (
  input  logic               clk,
  input  logic               rst_n,

  // apb slave, no wait states
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [3:0]         paddr_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,

  // to the source arbiter
  output logic [NUM_IRQ-1:0] irq_mask_o,

  // handler entry point for the fetch stage
  output logic [31:0]        handler_pc_o,

  // from the trap controller
  trap_csr_if.csr            csr
);

  logic                        irq_enable_q;
  logic [NUM_IRQ-1:0]          irq_mask_q;
  logic [trap_pkg::CAUSE_W-1:0] cause_q;
  logic [23:0]                 tvec_q;
  logic                        access;
  logic                        wr_en;
  logic                        mapped;
  logic [31:0]                 tvec_base;

  ////////////////////////////////////////
  // apb decode
  ////////////////////////////////////////

  // access phase, single cycle
  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  // only four word offsets exist
  always_comb
  begin
    mapped = 1'b1;
    case (paddr_i)
      trap_pkg::REG_STATUS:   prdata_o = {30'b0, csr.in_isr, irq_enable_q};
      trap_pkg::REG_IRQ_MASK: prdata_o = 32'(irq_mask_q);
      trap_pkg::REG_CAUSE:    prdata_o = 32'(cause_q);
      trap_pkg::REG_TVEC:     prdata_o = tvec_base;
      default:
      begin
        prdata_o = '0;
        mapped   = 1'b0;
      end
    endcase
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~mapped;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  // writes to CAUSE and to STATUS bit 1 fall through silently
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      irq_enable_q <= 1'b0;
      irq_mask_q   <= '0;
      tvec_q       <= '0;
    end
    else if (wr_en)
    begin
      case (paddr_i)
        trap_pkg::REG_STATUS:   irq_enable_q <= pwdata_i[0];
        trap_pkg::REG_IRQ_MASK: irq_mask_q   <= pwdata_i[NUM_IRQ-1:0];
        trap_pkg::REG_TVEC:     tvec_q       <= pwdata_i[31:8];
      endcase
    end
  end

  // saved cause, taken on the acknowledged transfer only
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cause_q <= '0;
    else if (csr.save_cause)
      cause_q <= csr.cause;
  end

  assign csr.irq_enable = irq_enable_q;
  assign irq_mask_o     = irq_mask_q;

  ////////////////////////////////////////
  // handler address
  ////////////////////////////////////////

  // 256-byte aligned table base
  assign tvec_base = {tvec_q, 8'h00};

  // interrupts use the upper half of the table, exceptions the lower
  always_comb
  begin
    if (csr.cause.irq.is_irq)
      handler_pc_o = tvec_base + trap_pkg::IRQ_VEC_OFFSET
                     + {25'b0, csr.cause.irq.id, 2'b00};
    else
      handler_pc_o = tvec_base + {25'b0, csr.cause.exc.code, 2'b00};
  end

endmodule

/* source/trap_csr_if.sv */
/* link between the trap controller and the apb register block
   ctrl side reports the trap, csr side returns the global enable */

`timescale 1ns/1ps

interface trap_csr_if;

  // one-cycle pulse on the acknowledged transfer
  logic             save_cause;
  // live cause, bypassed or latched
  trap_pkg::cause_t cause;
  // high while the handler runs
  logic             in_isr;
  // global interrupt enable from STATUS bit 0
  logic             irq_enable;

  // controller end
  modport ctrl (
    output save_cause,
    output cause,
    output in_isr,
    input  irq_enable
  );

  // register block end
  modport csr (
    input  save_cause,
    input  cause,
    input  in_isr,
    output irq_enable
  );

endinterface

/* source/trap_ctrl.sv */
/* trap request FSM, offers the trap to the pipeline controller and holds it
   until ack, then stays in the handler state until eret */

`timescale 1ns/1ps

module trap_ctrl (
  input  logic             clk,
  input  logic             rst_n,

  // from the source arbiter
  input  logic             trap_req_i,
  input  trap_pkg::cause_t trap_cause_i,
  input  logic             eret_i,

  // pipeline controller handshake
  output logic             req_o,
  input  logic             ack_i,
  output trap_pkg::cause_t cause_o,

  // to the register block
  trap_csr_if.ctrl         csr
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_ACK,
    IN_ISR
  } state_e;

  state_e           state_q;
  state_e           state_d;
  logic             offer;
  trap_pkg::cause_t cause_q;

  // first cycle of a new request
  assign offer = (state_q == IDLE) && csr.irq_enable && trap_req_i;

  ////////////////////////////////////////
  // cause latch with bypass
  ////////////////////////////////////////

  // capture once, at the edge closing the first offer cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cause_q <= '0;
    else if (offer)
      cause_q <= trap_cause_i;
  end

  // live cause in the offer cycle, frozen afterwards
  assign cause_o = offer ? trap_cause_i : cause_q;

  ////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    req_o          = 1'b0;
    csr.save_cause = 1'b0;

    unique case (state_q)
      IDLE:
      begin
        req_o = offer;
        if (offer)
        begin
          // ack may already meet the first request cycle
          if (ack_i)
          begin
            csr.save_cause = 1'b1;
            state_d        = IN_ISR;
          end
          else
            state_d = WAIT_ACK;
        end
      end

      WAIT_ACK:
      begin
        req_o = 1'b1;
        if (ack_i)
        begin
          csr.save_cause = 1'b1;
          state_d        = IN_ISR;
        end
      end

      IN_ISR:
      begin
        // new sources ignored here
        if (eret_i)
          state_d = IDLE;
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // handler flag for STATUS bit 1
  assign csr.in_isr = (state_q == IN_ISR);

  // live cause goes to the register block as well
  assign csr.cause = cause_o;

endmodule

/* source/trap_pkg.sv */
/* shared cause encodings, register offsets and vector offsets for the trap unit
   referenced by scoped name from every design file that needs them */

package trap_pkg;

  ////////////////////////////////////////
  // cause word
  ////////////////////////////////////////

  // top bit flags an interrupt, low bits hold id or code
  parameter int CAUSE_W = 6;

  // interrupt view of the cause word
  typedef struct packed {
    logic               is_irq;
    logic [CAUSE_W-2:0] id;
  } irq_cause_t;

  // exception view of the cause word
  typedef struct packed {
    logic               is_irq;
    logic [CAUSE_W-2:0] code;
  } exc_cause_t;

  // one word, decoded by the flag in its top bit
  typedef union packed {
    irq_cause_t irq;
    exc_cause_t exc;
  } cause_t;

  // synchronous exception codes
  parameter logic [CAUSE_W-2:0] EXC_ILLEGAL = 5'd2;
  parameter logic [CAUSE_W-2:0] EXC_ECALL   = 5'd8;

  ////////////////////////////////////////
  // apb register map
  ////////////////////////////////////////

  // byte offsets within the register block
  parameter logic [3:0] REG_STATUS   = 4'h0;
  parameter logic [3:0] REG_IRQ_MASK = 4'h4;
  parameter logic [3:0] REG_CAUSE    = 4'h8;
  parameter logic [3:0] REG_TVEC     = 4'hC;

  // interrupt handlers sit above the exception slots
  parameter logic [31:0] IRQ_VEC_OFFSET = 32'h0000_0080;

endpackage

/* source/trap_source_arbiter.sv */
/* registers and masks the interrupt lines, then picks the winning trap source
   exceptions override interrupts, lowest pending line wins among interrupts */

`timescale 1ns/1ps

module trap_source_arbiter #(
  parameter int NUM_IRQ = 32
) (
  input  logic             clk,
  input  logic             rst_n,

  // level interrupt lines and their mask
  input  logic [NUM_IRQ-1:0] irq_i,
  input  logic [NUM_IRQ-1:0] irq_mask_i,

  // decoder events, same cycle
  input  logic             illegal_insn_i,
  input  logic             ecall_insn_i,
  input  logic             eret_insn_i,

  // towards the controller
  output logic             trap_req_o,
  output trap_pkg::cause_t trap_cause_o,
  output logic             eret_o
);

  logic [NUM_IRQ-1:0] irq_q;
  logic [NUM_IRQ-1:0] irq_pending;

  ////////////////////////////////////////
  // interrupt input stage
  ////////////////////////////////////////

  // one register stage on the raw lines
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      irq_q <= '0;
    else
      irq_q <= irq_i;
  end

  // a line counts only with its mask bit set
  assign irq_pending = irq_q & irq_mask_i;

  ////////////////////////////////////////
  // cause selection
  ////////////////////////////////////////

  always_comb
  begin
    trap_cause_o = '0;

    // scan downwards so the lowest pending index is written last
    for (int i = NUM_IRQ - 1; i >= 0; i--)
    begin
      if (irq_pending[i])
      begin
        trap_cause_o.irq.is_irq = 1'b1;
        trap_cause_o.irq.id     = 5'(i);
      end
    end

    // ecall beats any interrupt
    if (ecall_insn_i)
    begin
      trap_cause_o.exc.is_irq = 1'b0;
      trap_cause_o.exc.code   = trap_pkg::EXC_ECALL;
    end

    // illegal beats everything
    if (illegal_insn_i)
    begin
      trap_cause_o.exc.is_irq = 1'b0;
      trap_cause_o.exc.code   = trap_pkg::EXC_ILLEGAL;
    end
  end

  // any source at all
  assign trap_req_o = illegal_insn_i | ecall_insn_i | (|irq_pending);

  // return from handler, passed on untouched
  assign eret_o = eret_insn_i;

endmodule

/* source/trap_unit.sv */
/* top level of the trap-entry unit, wires arbiter, FSM and register block
   exposes plain ports toward the pipeline and the apb bus */

`timescale 1ns/1ps

module trap_unit #(
  parameter int NUM_IRQ = 32
) (
  input  logic                         clk,
  input  logic                         rst_n,

  // trap sources
  input  logic [NUM_IRQ-1:0]           irq_i,
  input  logic                         illegal_insn_i,
  input  logic                         ecall_insn_i,
  input  logic                         eret_insn_i,

  // pipeline controller side
  output logic                         req_o,
  input  logic                         ack_i,
  output logic [trap_pkg::CAUSE_W-1:0] cause_o,
  output logic [31:0]                  handler_pc_o,

  // apb register access
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [3:0]                   paddr_i,
  input  logic [31:0]                  pwdata_i,
  output logic [31:0]                  prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o
);

  logic [NUM_IRQ-1:0] irq_mask;
  logic               trap_req;
  trap_pkg::cause_t   trap_cause;
  logic               eret;
  trap_pkg::cause_t   ctrl_cause;

  // controller to register block
  trap_csr_if csr_if ();

  // source registering and priority pick
  trap_source_arbiter #(
    .NUM_IRQ        (NUM_IRQ)
  ) arbiter0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_i          (irq_i),
    .irq_mask_i     (irq_mask),
    .illegal_insn_i (illegal_insn_i),
    .ecall_insn_i   (ecall_insn_i),
    .eret_insn_i    (eret_insn_i),
    .trap_req_o     (trap_req),
    .trap_cause_o   (trap_cause),
    .eret_o         (eret)
  );

  // request and handler FSM
  trap_ctrl ctrl0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .trap_req_i     (trap_req),
    .trap_cause_i   (trap_cause),
    .eret_i         (eret),
    .req_o          (req_o),
    .ack_i          (ack_i),
    .cause_o        (ctrl_cause),
    .csr            (csr_if.ctrl)
  );

  // register block and handler address
  trap_csr_apb #(
    .NUM_IRQ        (NUM_IRQ)
  ) csr0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .irq_mask_o     (irq_mask),
    .handler_pc_o   (handler_pc_o),
    .csr            (csr_if.csr)
  );

  // flat cause word on the port
  assign cause_o = ctrl_cause;

endmodule
